/* verilog/slv_guard_pkg.sv */
/*
 * Shared types and constants of the AXI4-Lite subordinate guard.
 * Covers bus field widths, response codes, register map and guard states.
 */
package slv_guard_pkg;

  // AXI4-Lite fields
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Latency counter and budget
  typedef logic [15:0] cnt_t;

  localparam cnt_t BUDGET_RESET = 16'd16;

  // Register port offsets
  typedef logic [4:0] reg_addr_t;

  localparam reg_addr_t REG_BUDGET_WR  = 5'h00;
  localparam reg_addr_t REG_BUDGET_RD  = 5'h04;
  localparam reg_addr_t REG_STATUS     = 5'h08;
  localparam reg_addr_t REG_FAULT_ADDR = 5'h0C;
  localparam reg_addr_t REG_CLEAR      = 5'h10;

  // Guard FSM, shared by the write and read side
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    FAULT
  } guard_state_e;

endpackage

/* verilog/slv_guard_regs.sv */
`timescale 1ns/1ps
/*
 * Configuration and status registers of the subordinate guard.
 * Holds both latency budgets, the fault flags and the first fault address.
 */
module slv_guard_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Register port
  input  logic                     reg_req_i,
  input  logic                     reg_we_i,
  input  slv_guard_pkg::reg_addr_t reg_addr_i,
  input  slv_guard_pkg::data_t     reg_wdata_i,
  output slv_guard_pkg::data_t     reg_rdata_o,
  output logic                     reg_rvalid_o,
  // Fault reports from the guards
  input  logic                     wr_fault_set_i,
  input  logic                     rd_fault_set_i,
  input  slv_guard_pkg::addr_t     wr_fault_addr_i,
  input  slv_guard_pkg::addr_t     rd_fault_addr_i,
  // Configuration towards the guards
  output slv_guard_pkg::cnt_t      budget_wr_o,
  output slv_guard_pkg::cnt_t      budget_rd_o,
  output logic                     fault_clear_o
);

  slv_guard_pkg::cnt_t  budget_wr_q;
  slv_guard_pkg::cnt_t  budget_rd_q;
  logic [1:0]           status_q;
  slv_guard_pkg::addr_t fault_addr_q;
  logic                 fault_clear_q;
  logic                 rvalid_q;
  logic                 wr_req;
  logic                 rd_req;
  logic                 clear_req;

  assign wr_req    = reg_req_i & reg_we_i;
  assign rd_req    = reg_req_i & ~reg_we_i;
  assign clear_req = wr_req && (reg_addr_i == slv_guard_pkg::REG_CLEAR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      budget_wr_q   <= slv_guard_pkg::BUDGET_RESET;
      budget_rd_q   <= slv_guard_pkg::BUDGET_RESET;
      status_q      <= 2'b00;
      fault_addr_q  <= '0;
      fault_clear_q <= 1'b0;
      rvalid_q      <= 1'b0;
    end else begin
      rvalid_q      <= rd_req;
      fault_clear_q <= clear_req;

      if (wr_req && (reg_addr_i == slv_guard_pkg::REG_BUDGET_WR)) begin
        budget_wr_q <= slv_guard_pkg::cnt_t'(reg_wdata_i);
      end
      if (wr_req && (reg_addr_i == slv_guard_pkg::REG_BUDGET_RD)) begin
        budget_rd_q <= slv_guard_pkg::cnt_t'(reg_wdata_i);
      end

      // Only the first fault since the last clear records its address
      if ((status_q == 2'b00) || clear_req) begin
        if (wr_fault_set_i) begin
          fault_addr_q <= wr_fault_addr_i;
        end else if (rd_fault_set_i) begin
          fault_addr_q <= rd_fault_addr_i;
        end
      end

      // A fault in the same cycle as a clear survives it
      if (clear_req) begin
        status_q <= 2'b00;
      end
      if (wr_fault_set_i) begin
        status_q[0] <= 1'b1;
      end
      if (rd_fault_set_i) begin
        status_q[1] <= 1'b1;
      end
    end
  end

  // Read data, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      case (reg_addr_i)
        slv_guard_pkg::REG_BUDGET_WR:  reg_rdata_o <= slv_guard_pkg::data_t'(budget_wr_q);
        slv_guard_pkg::REG_BUDGET_RD:  reg_rdata_o <= slv_guard_pkg::data_t'(budget_rd_q);
        slv_guard_pkg::REG_STATUS:     reg_rdata_o <= slv_guard_pkg::data_t'(status_q);
        slv_guard_pkg::REG_FAULT_ADDR: reg_rdata_o <= fault_addr_q;
        default:                       reg_rdata_o <= '0;
      endcase
    end
  end

  assign reg_rvalid_o  = rvalid_q;
  assign budget_wr_o   = budget_wr_q;
  assign budget_rd_o   = budget_rd_q;
  assign fault_clear_o = fault_clear_q;

  // Read response only ever follows a read request by exactly one cycle
  a_rvalid_after_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    reg_rvalid_o |-> $past(reg_req_i && !reg_we_i)
  );

endmodule

/* verilog/write_guard.sv */
`timescale 1ns/1ps
/*
 * Write guard for one AXI4-Lite write in flight.
 * Passes AW, W and B through, times the subordinate and answers SLVERR
 * itself on timeout, then isolates the subordinate until cleared.
 */
module write_guard #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 guard_ena_i,
  input  slv_guard_pkg::cnt_t  budget_i,
  input  logic                 fault_clear_i,
  // Manager side
  input  logic                 m_awvalid_i,
  input  slv_guard_pkg::addr_t m_awaddr_i,
  output logic                 m_awready_o,
  input  logic                 m_wvalid_i,
  input  slv_guard_pkg::data_t m_wdata_i,
  input  slv_guard_pkg::strb_t m_wstrb_i,
  output logic                 m_wready_o,
  output logic                 m_bvalid_o,
  output slv_guard_pkg::resp_t m_bresp_o,
  input  logic                 m_bready_i,
  // Subordinate side
  output logic                 s_awvalid_o,
  output slv_guard_pkg::addr_t s_awaddr_o,
  input  logic                 s_awready_i,
  output logic                 s_wvalid_o,
  output slv_guard_pkg::data_t s_wdata_o,
  output slv_guard_pkg::strb_t s_wstrb_o,
  input  logic                 s_wready_i,
  input  logic                 s_bvalid_i,
  input  slv_guard_pkg::resp_t s_bresp_i,
  output logic                 s_bready_o,
  // Fault reporting
  output logic                 fault_o,
  output logic                 fault_set_o,
  output slv_guard_pkg::addr_t fault_addr_o
);

  slv_guard_pkg::guard_state_e state_q, state_d;
  logic [CntWidth-1:0]         cnt_q;
  logic [CntWidth-1:0]         budget;
  slv_guard_pkg::addr_t        addr_q;
  logic                        aw_taken_q;
  logic                        w_taken_q;
  logic                        err_valid_q;
  logic                        busy;
  logic                        faulted;
  logic                        aw_sub_hs;
  logic                        w_sub_hs;
  logic                        b_done;
  logic                        timeout;
  logic                        aw_take;
  logic                        w_take;
  logic                        err_fire;

  assign budget  = CntWidth'(budget_i);
  assign busy    = (state_q == slv_guard_pkg::BUSY);
  assign faulted = (state_q == slv_guard_pkg::FAULT);

  assign s_awaddr_o = m_awaddr_i;
  assign s_wdata_o  = m_wdata_i;
  assign s_wstrb_o  = m_wstrb_i;

  // Handshake valids and readies
  always_comb begin
    s_awvalid_o = (state_q == slv_guard_pkg::IDLE) & m_awvalid_i;
    m_awready_o = (state_q == slv_guard_pkg::IDLE) & s_awready_i;
    s_wvalid_o  = ~faulted & ~w_taken_q & m_wvalid_i;
    m_wready_o  = ~faulted & ~w_taken_q & s_wready_i;
    m_bvalid_o  = busy & s_bvalid_i;
    m_bresp_o   = busy ? s_bresp_i : slv_guard_pkg::RESP_SLVERR;
    // Stray and late responses are absorbed outside BUSY
    s_bready_o  = busy ? m_bready_i : 1'b1;
    if (faulted) begin
      m_awready_o = ~aw_taken_q & ~err_valid_q;
      m_wready_o  = ~w_taken_q & ~err_valid_q;
      m_bvalid_o  = err_valid_q;
    end
  end

  assign aw_sub_hs = s_awvalid_o & s_awready_i;
  assign w_sub_hs  = s_wvalid_o & s_wready_i;
  assign b_done    = busy & s_bvalid_i & m_bready_i;
  assign timeout   = busy & guard_ena_i & ~s_bvalid_i & (cnt_q >= budget);
  assign aw_take   = faulted & m_awvalid_i & m_awready_o;
  assign w_take    = faulted & m_wvalid_i & m_wready_o;
  // Local SLVERR once both address and data are held
  assign err_fire  = faulted & ~err_valid_q & (aw_taken_q | aw_take) & (w_taken_q | w_take);

  always_comb begin
    state_d = state_q;
    case (state_q)
      slv_guard_pkg::IDLE:  if (aw_sub_hs) state_d = slv_guard_pkg::BUSY;
      slv_guard_pkg::BUSY: begin
        if (b_done) begin
          state_d = slv_guard_pkg::IDLE;
        end else if (timeout) begin
          state_d = slv_guard_pkg::FAULT;
        end
      end
      default:              if (fault_clear_i) state_d = slv_guard_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= slv_guard_pkg::IDLE;
      cnt_q       <= '0;
      aw_taken_q  <= 1'b0;
      w_taken_q   <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (!busy) begin
        cnt_q <= '0;
      end else if (guard_ena_i && !s_bvalid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (w_sub_hs) w_taken_q <= 1'b1;
      if (b_done) w_taken_q <= 1'b0;
      if (timeout) aw_taken_q <= 1'b1;

      if (faulted) begin
        if (fault_clear_i) begin
          aw_taken_q  <= 1'b0;
          w_taken_q   <= 1'b0;
          err_valid_q <= 1'b0;
        end else if (err_fire) begin
          aw_taken_q  <= 1'b0;
          w_taken_q   <= 1'b0;
          err_valid_q <= 1'b1;
        end else begin
          if (aw_take) aw_taken_q <= 1'b1;
          if (w_take) w_taken_q <= 1'b1;
          if (err_valid_q && m_bready_i) err_valid_q <= 1'b0;
        end
      end
    end
  end

  // Address of the write in flight
  always_ff @(posedge clk_i) begin
    if (aw_sub_hs) addr_q <= m_awaddr_i;
  end

  assign fault_o      = faulted;
  assign fault_set_o  = timeout;
  assign fault_addr_o = addr_q;

  a_no_b_in_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q == slv_guard_pkg::IDLE) |-> !m_bvalid_o
  );

endmodule

/* verilog/read_guard.sv */
`timescale 1ns/1ps
/*
 * Read guard for one AXI4-Lite read in flight.
 * Passes AR and R through, times the subordinate and answers zero data
 * with SLVERR on timeout, then isolates the subordinate until cleared.
 */
module read_guard #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 guard_ena_i,
  input  slv_guard_pkg::cnt_t  budget_i,
  input  logic                 fault_clear_i,
  // Manager side
  input  logic                 m_arvalid_i,
  input  slv_guard_pkg::addr_t m_araddr_i,
  output logic                 m_arready_o,
  output logic                 m_rvalid_o,
  output slv_guard_pkg::data_t m_rdata_o,
  output slv_guard_pkg::resp_t m_rresp_o,
  input  logic                 m_rready_i,
  // Subordinate side
  output logic                 s_arvalid_o,
  output slv_guard_pkg::addr_t s_araddr_o,
  input  logic                 s_arready_i,
  input  logic                 s_rvalid_i,
  input  slv_guard_pkg::data_t s_rdata_i,
  input  slv_guard_pkg::resp_t s_rresp_i,
  output logic                 s_rready_o,
  // Fault reporting
  output logic                 fault_o,
  output logic                 fault_set_o,
  output slv_guard_pkg::addr_t fault_addr_o
);

  slv_guard_pkg::guard_state_e state_q, state_d;
  logic [CntWidth-1:0]         cnt_q;
  logic [CntWidth-1:0]         budget;
  slv_guard_pkg::addr_t        addr_q;
  logic                        ar_taken_q;
  logic                        err_valid_q;
  logic                        busy;
  logic                        faulted;
  logic                        ar_sub_hs;
  logic                        r_done;
  logic                        timeout;
  logic                        ar_take;
  logic                        err_fire;

  assign budget  = CntWidth'(budget_i);
  assign busy    = (state_q == slv_guard_pkg::BUSY);
  assign faulted = (state_q == slv_guard_pkg::FAULT);

  assign s_araddr_o  = m_araddr_i;
  assign s_arvalid_o = (state_q == slv_guard_pkg::IDLE) & m_arvalid_i;
  // Late reads are dropped while isolated
  assign s_rready_o  = busy ? m_rready_i : 1'b1;

  assign m_arready_o = faulted ? (~ar_taken_q & ~err_valid_q)
                               : ((state_q == slv_guard_pkg::IDLE) & s_arready_i);
  assign m_rvalid_o  = faulted ? err_valid_q : (busy & s_rvalid_i);
  assign m_rdata_o   = busy ? s_rdata_i : '0;
  assign m_rresp_o   = busy ? s_rresp_i : slv_guard_pkg::RESP_SLVERR;

  assign ar_sub_hs = s_arvalid_o & s_arready_i;
  assign r_done    = busy & s_rvalid_i & m_rready_i;
  assign timeout   = busy & guard_ena_i & ~s_rvalid_i & (cnt_q >= budget);
  assign ar_take   = faulted & m_arvalid_i & m_arready_o;
  assign err_fire  = faulted & ~err_valid_q & (ar_taken_q | ar_take);

  always_comb begin
    state_d = state_q;
    case (state_q)
      slv_guard_pkg::IDLE:  if (ar_sub_hs) state_d = slv_guard_pkg::BUSY;
      slv_guard_pkg::BUSY: begin
        if (r_done) begin
          state_d = slv_guard_pkg::IDLE;
        end else if (timeout) begin
          state_d = slv_guard_pkg::FAULT;
        end
      end
      default:              if (fault_clear_i) state_d = slv_guard_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= slv_guard_pkg::IDLE;
      cnt_q       <= '0;
      ar_taken_q  <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Counter holds once the subordinate has answered
      if (!busy) begin
        cnt_q <= '0;
      end else if (guard_ena_i && !s_rvalid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (timeout) ar_taken_q <= 1'b1;

      if (faulted) begin
        if (fault_clear_i) begin
          ar_taken_q  <= 1'b0;
          err_valid_q <= 1'b0;
        end else if (err_fire) begin
          ar_taken_q  <= 1'b0;
          err_valid_q <= 1'b1;
        end else if (err_valid_q && m_rready_i) begin
          err_valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_sub_hs) addr_q <= m_araddr_i;
  end

  assign fault_o      = faulted;
  assign fault_set_o  = timeout;
  assign fault_addr_o = addr_q;

  a_no_r_in_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q == slv_guard_pkg::IDLE) |-> !m_rvalid_o
  );

endmodule

/* verilog/slv_guard_top.sv */
`timescale 1ns/1ps
/*
 * Subordinate guard top level for AXI4-Lite.
 * Joins the register block with the write and read guards.
 */
module slv_guard_top #(
  parameter int unsigned CntWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     guard_ena_i,
  // Manager port
  input  logic                     m_awvalid_i,
  input  slv_guard_pkg::addr_t     m_awaddr_i,
  output logic                     m_awready_o,
  input  logic                     m_wvalid_i,
  input  slv_guard_pkg::data_t     m_wdata_i,
  input  slv_guard_pkg::strb_t     m_wstrb_i,
  output logic                     m_wready_o,
  output logic                     m_bvalid_o,
  output slv_guard_pkg::resp_t     m_bresp_o,
  input  logic                     m_bready_i,
  input  logic                     m_arvalid_i,
  input  slv_guard_pkg::addr_t     m_araddr_i,
  output logic                     m_arready_o,
  output logic                     m_rvalid_o,
  output slv_guard_pkg::data_t     m_rdata_o,
  output slv_guard_pkg::resp_t     m_rresp_o,
  input  logic                     m_rready_i,
  // Subordinate port
  output logic                     s_awvalid_o,
  output slv_guard_pkg::addr_t     s_awaddr_o,
  input  logic                     s_awready_i,
  output logic                     s_wvalid_o,
  output slv_guard_pkg::data_t     s_wdata_o,
  output slv_guard_pkg::strb_t     s_wstrb_o,
  input  logic                     s_wready_i,
  input  logic                     s_bvalid_i,
  input  slv_guard_pkg::resp_t     s_bresp_i,
  output logic                     s_bready_o,
  output logic                     s_arvalid_o,
  output slv_guard_pkg::addr_t     s_araddr_o,
  input  logic                     s_arready_i,
  input  logic                     s_rvalid_i,
  input  slv_guard_pkg::data_t     s_rdata_i,
  input  slv_guard_pkg::resp_t     s_rresp_i,
  output logic                     s_rready_o,
  // Register port
  input  logic                     reg_req_i,
  input  logic                     reg_we_i,
  input  slv_guard_pkg::reg_addr_t reg_addr_i,
  input  slv_guard_pkg::data_t     reg_wdata_i,
  output slv_guard_pkg::data_t     reg_rdata_o,
  output logic                     reg_rvalid_o,
  // Fault signalling
  output logic                     irq_o,
  output logic                     rst_req_o
);

  slv_guard_pkg::cnt_t  budget_wr;
  slv_guard_pkg::cnt_t  budget_rd;
  logic                 fault_clear;
  logic                 wr_fault;
  logic                 rd_fault;
  logic                 wr_fault_set;
  logic                 rd_fault_set;
  slv_guard_pkg::addr_t wr_fault_addr;
  slv_guard_pkg::addr_t rd_fault_addr;

  slv_guard_regs i_regs (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .reg_req_i       ( reg_req_i     ),
    .reg_we_i        ( reg_we_i      ),
    .reg_addr_i      ( reg_addr_i    ),
    .reg_wdata_i     ( reg_wdata_i   ),
    .reg_rdata_o     ( reg_rdata_o   ),
    .reg_rvalid_o    ( reg_rvalid_o  ),
    .wr_fault_set_i  ( wr_fault_set  ),
    .rd_fault_set_i  ( rd_fault_set  ),
    .wr_fault_addr_i ( wr_fault_addr ),
    .rd_fault_addr_i ( rd_fault_addr ),
    .budget_wr_o     ( budget_wr     ),
    .budget_rd_o     ( budget_rd     ),
    .fault_clear_o   ( fault_clear   )
  );

  write_guard #(
    .CntWidth ( CntWidth )
  ) i_write_guard (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .guard_ena_i   ( guard_ena_i   ),
    .budget_i      ( budget_wr     ),
    .fault_clear_i ( fault_clear   ),
    .m_awvalid_i   ( m_awvalid_i   ),
    .m_awaddr_i    ( m_awaddr_i    ),
    .m_awready_o   ( m_awready_o   ),
    .m_wvalid_i    ( m_wvalid_i    ),
    .m_wdata_i     ( m_wdata_i     ),
    .m_wstrb_i     ( m_wstrb_i     ),
    .m_wready_o    ( m_wready_o    ),
    .m_bvalid_o    ( m_bvalid_o    ),
    .m_bresp_o     ( m_bresp_o     ),
    .m_bready_i    ( m_bready_i    ),
    .s_awvalid_o   ( s_awvalid_o   ),
    .s_awaddr_o    ( s_awaddr_o    ),
    .s_awready_i   ( s_awready_i   ),
    .s_wvalid_o    ( s_wvalid_o    ),
    .s_wdata_o     ( s_wdata_o     ),
    .s_wstrb_o     ( s_wstrb_o     ),
    .s_wready_i    ( s_wready_i    ),
    .s_bvalid_i    ( s_bvalid_i    ),
    .s_bresp_i     ( s_bresp_i     ),
    .s_bready_o    ( s_bready_o    ),
    .fault_o       ( wr_fault      ),
    .fault_set_o   ( wr_fault_set  ),
    .fault_addr_o  ( wr_fault_addr )
  );

  read_guard #(
    .CntWidth ( CntWidth )
  ) i_read_guard (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .guard_ena_i   ( guard_ena_i   ),
    .budget_i      ( budget_rd     ),
    .fault_clear_i ( fault_clear   ),
    .m_arvalid_i   ( m_arvalid_i   ),
    .m_araddr_i    ( m_araddr_i    ),
    .m_arready_o   ( m_arready_o   ),
    .m_rvalid_o    ( m_rvalid_o    ),
    .m_rdata_o     ( m_rdata_o     ),
    .m_rresp_o     ( m_rresp_o     ),
    .m_rready_i    ( m_rready_i    ),
    .s_arvalid_o   ( s_arvalid_o   ),
    .s_araddr_o    ( s_araddr_o    ),
    .s_arready_i   ( s_arready_i   ),
    .s_rvalid_i    ( s_rvalid_i    ),
    .s_rdata_i     ( s_rdata_i     ),
    .s_rresp_i     ( s_rresp_i     ),
    .s_rready_o    ( s_rready_o    ),
    .fault_o       ( rd_fault      ),
    .fault_set_o   ( rd_fault_set  ),
    .fault_addr_o  ( rd_fault_addr )
  );

  // Both outputs stay up while either side is isolated
  assign irq_o     = wr_fault | rd_fault;
  assign rst_req_o = wr_fault | rd_fault;

endmodule

/* testbench/slv_guard_tb.sv */
`timescale 1ns/1ps
/*
 * Testbench for the AXI4-Lite subordinate guard.
 * Replays the vector file against a subordinate model with programmable delay.
 */
module slv_guard_tb;

  localparam int TIMEOUT = 200;

  logic        clk_i = 1'b0;
  logic        reset_i = 1'b1;
  logic        guard_ena_i = 1'b1;
  logic        m_awvalid_i = 1'b0, m_wvalid_i = 1'b0, m_bready_i = 1'b0;
  logic        m_arvalid_i = 1'b0, m_rready_i = 1'b0;
  logic [31:0] m_awaddr_i = '0, m_wdata_i = '0, m_araddr_i = '0;
  logic [3:0]  m_wstrb_i = '0;
  logic        m_awready_o, m_wready_o, m_bvalid_o, m_arready_o, m_rvalid_o;
  logic [1:0]  m_bresp_o, m_rresp_o;
  logic [31:0] m_rdata_o;
  logic        s_awvalid_o, s_wvalid_o, s_bready_o, s_arvalid_o, s_rready_o;
  logic [31:0] s_awaddr_o, s_wdata_o, s_araddr_o;
  logic [3:0]  s_wstrb_o;
  logic        s_awready_i = 1'b1, s_wready_i = 1'b1, s_arready_i = 1'b1;
  logic        s_bvalid_i = 1'b0, s_rvalid_i = 1'b0;
  logic [1:0]  s_bresp_i = '0, s_rresp_i = '0;
  logic [31:0] s_rdata_i = '0;
  logic        reg_req_i = 1'b0, reg_we_i = 1'b0, reg_rvalid_o;
  logic [4:0]  reg_addr_i = '0;
  logic [31:0] reg_wdata_i = '0, reg_rdata_o;
  logic        irq_o, rst_req_o;

  // Subordinate model state
  logic [31:0] mem [16];
  int          sub_delay = 0;
  int          addr_seen = 0;
  int          wr_cnt = 0, rd_cnt = 0, wr_delay = 0, rd_delay = 0;
  bit          wr_busy = 0, rd_busy = 0, b_hs = 0, r_hs = 0;
  logic [31:0] rd_addr = '0;
  int          fail_count = 0;
  int          pass_count = 0;

  always #2 clk_i = ~clk_i;

  slv_guard_top #(.CntWidth(16)) dut (.*);

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h1000_0000 + i;
    end
  end

  // Subordinate drives on the falling edge, then notes what the next rising edge takes
  always @(negedge clk_i) begin
    if (reset_i) begin
      s_bvalid_i = 1'b0;
      s_rvalid_i = 1'b0;
      wr_busy = 0;
      rd_busy = 0;
      b_hs = 0;
      r_hs = 0;
    end else begin
      if (b_hs) s_bvalid_i = 1'b0;
      if (r_hs) s_rvalid_i = 1'b0;
      b_hs = 0;
      r_hs = 0;
      // A delay of 255 never answers
      if (wr_busy && wr_delay != 255) begin
        if (wr_cnt >= wr_delay) begin
          s_bvalid_i = 1'b1;
          s_bresp_i = 2'b00;
          wr_busy = 0;
        end else begin
          wr_cnt++;
        end
      end
      if (rd_busy && rd_delay != 255) begin
        if (rd_cnt >= rd_delay) begin
          s_rvalid_i = 1'b1;
          s_rresp_i = 2'b00;
          s_rdata_i = mem[rd_addr[5:2]];
          rd_busy = 0;
        end else begin
          rd_cnt++;
        end
      end
      #1;
      if (s_awvalid_o && s_awready_i) begin
        addr_seen++;
        wr_busy = 1;
        wr_cnt = 0;
        wr_delay = sub_delay;
      end
      if (s_wvalid_o && s_wready_i) begin
        // Only the byte lanes enabled by the strobes are written
        for (int b = 0; b < 4; b++) begin
          if (s_wstrb_o[b]) mem[s_awaddr_o[5:2]][8*b +: 8] = s_wdata_o[8*b +: 8];
        end
      end
      if (s_arvalid_o && s_arready_i) begin
        addr_seen++;
        rd_busy = 1;
        rd_cnt = 0;
        rd_delay = sub_delay;
        rd_addr = s_araddr_o;
      end
      b_hs = s_bvalid_i && s_bready_o;
      r_hs = s_rvalid_i && s_rready_o;
    end
  end

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic [1:0] resp, output bit ok);
    bit aw_hs, w_hs, done;
    int cycles;
    done = 0;
    cycles = 0;
    resp = '0;
    @(negedge clk_i);
    m_awvalid_i = 1'b1;
    m_awaddr_i = addr;
    m_wvalid_i = 1'b1;
    m_wdata_i = data;
    m_wstrb_i = 4'hf;
    m_bready_i = 1'b1;
    while (!done && cycles < TIMEOUT) begin
      #1;
      aw_hs = m_awvalid_i && m_awready_o;
      w_hs = m_wvalid_i && m_wready_o;
      if (m_bvalid_o) begin
        done = 1;
        resp = m_bresp_o;
      end
      @(negedge clk_i);
      if (aw_hs) m_awvalid_i = 1'b0;
      if (w_hs) m_wvalid_i = 1'b0;
      cycles++;
    end
    m_awvalid_i = 1'b0;
    m_wvalid_i = 1'b0;
    m_bready_i = 1'b0;
    ok = done;
    if (!done) $display("Timeout: no write response within %0d cycles", TIMEOUT);
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output bit ok);
    bit ar_hs, done;
    int cycles;
    done = 0;
    cycles = 0;
    resp = '0;
    data = '0;
    @(negedge clk_i);
    m_arvalid_i = 1'b1;
    m_araddr_i = addr;
    m_rready_i = 1'b1;
    while (!done && cycles < TIMEOUT) begin
      #1;
      ar_hs = m_arvalid_i && m_arready_o;
      if (m_rvalid_o) begin
        done = 1;
        resp = m_rresp_o;
        data = m_rdata_o;
      end
      @(negedge clk_i);
      if (ar_hs) m_arvalid_i = 1'b0;
      cycles++;
    end
    m_arvalid_i = 1'b0;
    m_rready_i = 1'b0;
    ok = done;
    if (!done) $display("Timeout: no read response within %0d cycles", TIMEOUT);
  endtask

  task automatic reg_access(input bit we, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output bit ok);
    int cycles;
    cycles = 0;
    ok = we;
    rdata = '0;
    @(negedge clk_i);
    reg_req_i = 1'b1;
    reg_we_i = we;
    reg_addr_i = addr;
    reg_wdata_i = wdata;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    reg_we_i = 1'b0;
    while (!we && !ok && cycles < TIMEOUT) begin
      #1;
      if (reg_rvalid_o) begin
        ok = 1;
        rdata = reg_rdata_o;
      end else begin
        @(negedge clk_i);
      end
      cycles++;
    end
    if (!ok) $display("Timeout: register read never returned valid data");
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got,
                         inout bit good);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
      good = 0;
    end
  endtask

  initial begin
    int          fd, n, vec;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr, data, expv, rdata;
    logic [1:0]  resp;
    int          delay, exp_irq, seen_before;
    bit          ok, good, irq_before;
    vec = 0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    fd = $fopen("testbench/slv_guard_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() == 0 || line.substr(0, 0) == "#") continue;
        n = $sscanf(line, "%c %h %h %d %h %d", op, addr, data, delay, expv, exp_irq);
        if (n != 6) continue;
        vec++;
        good = 1;
        sub_delay = delay;
        seen_before = addr_seen;
        irq_before = irq_o;
        case (op)
          "W": begin
            axi_write(addr, data, resp, ok);
            if (ok) compare("m_bresp_o", expv, 32'(resp), good);
          end
          "R": begin
            axi_read(addr, rdata, resp, ok);
            if (ok) compare("m_rresp_o", expv, 32'(resp), good);
            if (ok) compare("m_rdata_o", data, rdata, good);
          end
          "C": reg_access(1'b1, addr[4:0], data, rdata, ok);
          default: begin
            reg_access(1'b0, addr[4:0], data, rdata, ok);
            if (ok) compare("reg_rdata_o", expv, rdata, good);
          end
        endcase
        if (!ok) good = 0;
        // An isolated side must keep every address away from the subordinate
        if (irq_before && (op == "W" || op == "R") && addr_seen != seen_before) begin
          $display("Subordinate saw an address while the guard was isolating it");
          good = 0;
        end
        repeat (3) @(negedge clk_i);
        #1;
        compare("irq_o", 32'(exp_irq), 32'(irq_o), good);
        compare("rst_req_o", 32'(exp_irq), 32'(rst_req_o), good);
        if (good) pass_count++;
        else fail_count++;
        $display("Vector %0d %c addr %0h: %s", vec, op, addr, good ? "pass" : "FAIL");
      end
      $fclose(fd);
    end
    $display("Vectors passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && vec > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* testbench/slv_guard_vectors.txt */
# op addr(hex) data(hex) sub_delay(dec) expected(hex) irq(dec)
# W/R expect a response code and R data is the expected read data, S expects the read value
S 00 00000000 0 10 0
S 04 00000000 0 10 0
C 00 00000020 0 0 0
S 00 00000000 0 20 0
W 10 cafe0001 3 0 0
W 14 12345678 5 0 0
R 10 cafe0001 4 0 0
R 14 12345678 0 0 0
W 20 aaaa5555 255 2 1
S 08 00000000 0 1 1
S 0c 00000000 0 20 1
W 14 0badf00d 1 2 1
C 10 00000000 0 0 0
S 08 00000000 0 0 0
C 04 00000004 0 0 0
S 04 00000000 0 4 0
R 10 00000000 10 2 1
S 08 00000000 0 2 1
C 10 00000000 0 0 0
R 14 12345678 2 0 0

/* sources.f */
verilog/slv_guard_pkg.sv
verilog/slv_guard_regs.sv
verilog/write_guard.sv
verilog/read_guard.sv
verilog/slv_guard_top.sv
testbench/slv_guard_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the guard testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f sources.f --top-module slv_guard_tb \
  -Mdir obj_dir -o slv_guard_sim
out=$(./obj_dir/slv_guard_sim)
echo "$out"
if echo "$out" | grep -q "Everything OK"; then
  exit 0
else
  exit 1
fi
